/* common/periph_params.svh */
// Peripheral subsystem constants
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Bus widths
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32

// Address map
`define SLOT_LSB      12
`define SLOT_W        4
`define REG_LSB       2
`define REG_IDX_W     3

`define SLOT_IRQ      4'd0
`define SLOT_TIMER    4'd1
`define SLOT_GPIO     4'd2

// Counts and widths of the peripherals
`define NUM_SOURCES   4
`define NUM_TARGETS   2
`define GPIO_W        8

`define ERR_RDATA     32'hDEAD_BEEF // Unmapped slot read word

`endif

/* common/periph_pkg.sv */
// Peripheral subsystem types
`include "periph_params.svh"

package periph_pkg;

    // ------------------------------------------------
    // Bus
    // ------------------------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] paddr_t;
    typedef logic [`PERIPH_DATA_W-1:0] pdata_t; // Also timer counts

    typedef logic [`SLOT_W-1:0]        slot_t;
    typedef logic [`REG_IDX_W-1:0]     reg_idx_t;

    // ------------------------------------------------
    // Interrupts and GPIO
    // ------------------------------------------------
    typedef logic [`NUM_SOURCES-1:0]   irq_src_t;  // One bit per source
    typedef logic [`NUM_TARGETS-1:0]   irq_tgt_t;  // One bit per target

    typedef logic [`GPIO_W-1:0]        gpio_t;

endpackage

/* hw/apb_ctrl.sv */
// APB slot decode and response
`include "periph_params.svh"

module apb_ctrl import periph_pkg::*; (
    // Bus side
    input  logic     psel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  paddr_t   paddr_i,
    input  pdata_t   pwdata_i,
    // Peripheral read words
    input  pdata_t   irq_rdata_i,
    input  pdata_t   timer_rdata_i,
    input  pdata_t   gpio_rdata_i,
    // Shared register access
    output reg_idx_t reg_idx_o,
    output pdata_t   wdata_o,
    output logic     irq_we_o,
    output logic     timer_we_o,
    output logic     gpio_we_o,
    // Response
    output pdata_t   prdata_o,
    output logic     pready_o,
    output logic     pslverr_o
);

    slot_t slot;
    logic  access;
    logic  wr_access;
    logic  mapped;

    // ------------------------------------------------
    // Address split
    // ------------------------------------------------
    assign slot      = paddr_i[`SLOT_LSB +: `SLOT_W];
    assign reg_idx_o = paddr_i[`REG_LSB +: `REG_IDX_W];
    assign wdata_o   = pwdata_i;

    // Every access cycle completes without wait states
    assign access    = psel_i && penable_i;
    assign wr_access = access && pwrite_i;
    assign pready_o  = access;

    // ------------------------------------------------
    // Write strobes
    // ------------------------------------------------
    assign irq_we_o   = wr_access && (slot == `SLOT_IRQ);
    assign timer_we_o = wr_access && (slot == `SLOT_TIMER);
    assign gpio_we_o  = wr_access && (slot == `SLOT_GPIO);

    // ------------------------------------------------
    // Read mux and error response
    // ------------------------------------------------
    always_comb begin
        mapped   = 1'b1;
        prdata_o = `ERR_RDATA;
        case (slot)
            `SLOT_IRQ:   prdata_o = irq_rdata_i;
            `SLOT_TIMER: prdata_o = timer_rdata_i;
            `SLOT_GPIO:  prdata_o = gpio_rdata_i;
            default:     mapped   = 1'b0; // Absent peripheral
        endcase
    end

    assign pslverr_o = access && !mapped;

endmodule

/* hw/gpio_regs.sv */
// LED and DIP-switch port
`include "periph_params.svh"

module gpio_regs import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     we_i,
    input  reg_idx_t reg_idx_i,
    input  pdata_t   wdata_i,
    input  gpio_t    dip_switches_i,
    output pdata_t   rdata_o,
    output gpio_t    leds_o
);

    gpio_t leds_q;
    gpio_t dip_meta_q; // First sync stage
    gpio_t dip_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            leds_q     <= '0;
            dip_meta_q <= '0;
            dip_q      <= '0;
        end else begin
            if (we_i && reg_idx_i == 3'd0) begin
                leds_q <= wdata_i[`GPIO_W-1:0];
            end
            dip_meta_q <= dip_switches_i;
            dip_q      <= dip_meta_q;
        end
    end

    always_comb begin
        case (reg_idx_i)
            3'd0:    rdata_o = pdata_t'(leds_q);
            3'd1:    rdata_o = pdata_t'(dip_q); // Read only
            default: rdata_o = '0;
        endcase
    end

    assign leds_o = leds_q;

endmodule

/* hw/irq_gateway.sv */
// Level interrupt gateway
`include "periph_params.svh"

module irq_gateway import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     we_i,
    input  reg_idx_t reg_idx_i,
    input  pdata_t   wdata_i,
    input  irq_src_t src_i,
    output pdata_t   rdata_o,
    output irq_tgt_t irq_o
);

    irq_src_t pend_q;
    irq_src_t pend_clr;
    irq_src_t en_q [`NUM_TARGETS];

    // Write 1 to clear
    assign pend_clr = (we_i && reg_idx_i == 3'd0) ? wdata_i[`NUM_SOURCES-1:0] : '0;

    // ------------------------------------------------
    // Pending and enable registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= '0;
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                en_q[t] <= '0;
            end
        end else begin
            pend_q <= (pend_q & ~pend_clr) | src_i; // Live source wins over clear
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                if (we_i && reg_idx_i == reg_idx_t'(t + 1)) begin
                    en_q[t] <= wdata_i[`NUM_SOURCES-1:0];
                end
            end
        end
    end

    // ------------------------------------------------
    // Target outputs and read back
    // ------------------------------------------------
    always_comb begin
        for (int t = 0; t < `NUM_TARGETS; t++) begin
            irq_o[t] = |(pend_q & en_q[t]);
        end
    end

    always_comb begin
        rdata_o = '0;
        if (reg_idx_i == 3'd0) begin
            rdata_o = pdata_t'(pend_q);
        end
        for (int t = 0; t < `NUM_TARGETS; t++) begin
            if (reg_idx_i == reg_idx_t'(t + 1)) begin
                rdata_o = pdata_t'(en_q[t]); // Enable mask of target t
            end
        end
    end

endmodule

/* timer/apb_timer_unit.sv */
// Two-channel compare timer
module apb_timer_unit import periph_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       we_i,
    input  reg_idx_t   reg_idx_i,
    input  pdata_t     wdata_i,
    output pdata_t     rdata_o,
    output logic [1:0] match_o
);

    pdata_t ch_rdata [2];

    // Index bit 2 picks the channel, bits 1:0 the register
    for (genvar c = 0; c < 2; c++) begin : gen_ch
        pdata_t cnt_q;
        pdata_t cmp_q;
        logic   en_q;
        logic   match_q;
        logic   ch_we;
        logic   hit;

        assign ch_we = we_i && (reg_idx_i[2] == 1'(c));
        assign hit   = en_q && (cnt_q == cmp_q);

        // ------------------------------------------------
        // Counter, control and compare
        // ------------------------------------------------
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                cnt_q   <= '0;
                cmp_q   <= '0;
                en_q    <= 1'b0;
                match_q <= 1'b0;
            end else begin
                if (ch_we && reg_idx_i[1:0] == 2'd0) begin
                    cnt_q <= wdata_i; // Load
                end else if (hit) begin
                    cnt_q <= '0;      // Wrap on compare
                end else if (en_q) begin
                    cnt_q <= cnt_q + 1'b1;
                end

                if (ch_we && reg_idx_i[1:0] == 2'd1) begin
                    en_q <= wdata_i[0];
                end
                if (ch_we && reg_idx_i[1:0] == 2'd2) begin
                    cmp_q <= wdata_i;
                end

                match_q <= hit; // One-cycle pulse
            end
        end

        always_comb begin
            case (reg_idx_i[1:0])
                2'd0:    ch_rdata[c] = cnt_q;
                2'd1:    ch_rdata[c] = pdata_t'(en_q);
                2'd2:    ch_rdata[c] = cmp_q;
                default: ch_rdata[c] = '0;
            endcase
        end

        assign match_o[c] = match_q;
    end

    // ------------------------------------------------
    // Read back
    // ------------------------------------------------
    assign rdata_o = ch_rdata[reg_idx_i[2]];

endmodule

/* hw/periph_top.sv */
// Peripheral subsystem top
module periph_top import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // APB slave
    input  logic     psel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  paddr_t   paddr_i,
    input  pdata_t   pwdata_i,
    output pdata_t   prdata_o,
    output logic     pready_o,
    output logic     pslverr_o,
    // Interrupts
    input  logic [1:0] ext_irq_i,
    output irq_tgt_t irq_o,
    // Board I/O
    input  gpio_t    dip_switches_i,
    output gpio_t    leds_o
);

    reg_idx_t   reg_idx;
    pdata_t     wdata;
    logic       irq_we;
    logic       timer_we;
    logic       gpio_we;
    pdata_t     irq_rdata;
    pdata_t     timer_rdata;
    pdata_t     gpio_rdata;
    logic [1:0] timer_match;
    irq_src_t   irq_sources;

    // Timers on the low sources, external lines above
    assign irq_sources = {ext_irq_i, timer_match};

    apb_ctrl i_apb_ctrl (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .reg_idx_o     ( reg_idx     ),
        .wdata_o       ( wdata       ),
        .irq_we_o      ( irq_we      ),
        .timer_we_o    ( timer_we    ),
        .gpio_we_o     ( gpio_we     ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    apb_timer_unit i_timer (
        .clk_i     ( clk_i       ),
        .arst_n_i  ( arst_n_i    ),
        .we_i      ( timer_we    ),
        .reg_idx_i ( reg_idx     ),
        .wdata_i   ( wdata       ),
        .rdata_o   ( timer_rdata ),
        .match_o   ( timer_match )
    );

    gpio_regs i_gpio (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .we_i           ( gpio_we        ),
        .reg_idx_i      ( reg_idx        ),
        .wdata_i        ( wdata          ),
        .dip_switches_i ( dip_switches_i ),
        .rdata_o        ( gpio_rdata     ),
        .leds_o         ( leds_o         )
    );

    irq_gateway i_irq_gateway (
        .clk_i     ( clk_i       ),
        .arst_n_i  ( arst_n_i    ),
        .we_i      ( irq_we      ),
        .reg_idx_i ( reg_idx     ),
        .wdata_i   ( wdata       ),
        .src_i     ( irq_sources ),
        .rdata_o   ( irq_rdata   ),
        .irq_o     ( irq_o       )
    );

endmodule

/* test/periph_chk.sv */
// Bus and peripheral assertions
`include "periph_params.svh"

module periph_chk import periph_pkg::*; (
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pwrite_i,
    input paddr_t     paddr_i,
    input pdata_t     pwdata_i,
    input pdata_t     prdata_o,
    input logic       pready_o,
    input logic       pslverr_o,
    input logic [1:0] ext_irq_i,
    input irq_tgt_t   irq_o,
    input gpio_t      dip_switches_i,
    input gpio_t      leds_o,
    input irq_src_t   irq_sources_i
);

    int       err_cnt = 0;
    slot_t    slot;
    reg_idx_t idx;
    logic     acc;
    logic     wr_acc;
    logic     rd_acc;
    irq_src_t en_model [2];  // Target enable masks seen on the bus
    pdata_t   cmp_model [2];
    gpio_t    led_model;
    gpio_t    dip_last;
    logic [1:0] dip_stable;  // Saturating count of unchanged samples

    assign slot   = paddr_i[`SLOT_LSB +: `SLOT_W];
    assign idx    = paddr_i[`REG_LSB +: `REG_IDX_W];
    assign acc    = psel_i && penable_i;
    assign wr_acc = acc && pwrite_i;
    assign rd_acc = acc && !pwrite_i;

    function automatic void record_failure(input string msg);
        err_cnt++;
        $error("%s", msg);
    endfunction

    // ------------------------------------------------
    // Register models from bus traffic
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_model[0]  <= '0;
            en_model[1]  <= '0;
            cmp_model[0] <= '0;
            cmp_model[1] <= '0;
            led_model    <= '0;
            dip_last     <= '0;
            dip_stable   <= '0;
        end else begin
            if (wr_acc && slot == `SLOT_IRQ && idx == 3'd1) begin
                en_model[0] <= pwdata_i[`NUM_SOURCES-1:0];
            end
            if (wr_acc && slot == `SLOT_IRQ && idx == 3'd2) begin
                en_model[1] <= pwdata_i[`NUM_SOURCES-1:0];
            end
            if (wr_acc && slot == `SLOT_TIMER && idx == 3'd2) begin
                cmp_model[0] <= pwdata_i;
            end
            if (wr_acc && slot == `SLOT_TIMER && idx == 3'd6) begin
                cmp_model[1] <= pwdata_i;
            end
            if (wr_acc && slot == `SLOT_GPIO && idx == 3'd0) begin
                led_model <= pwdata_i[`GPIO_W-1:0];
            end
            dip_last <= dip_switches_i;
            if (dip_switches_i != dip_last) begin
                dip_stable <= '0;
            end else if (dip_stable != 2'd3) begin
                dip_stable <= dip_stable + 2'd1;
            end
        end
    end

    // ------------------------------------------------
    // Bus response
    // ------------------------------------------------
    a_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i) pready_o == acc)
        else record_failure($sformatf("FAILED pready_o: got %h, expected %h", pready_o, acc));
    a_unmapped_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (acc && slot > `SLOT_GPIO) |-> pslverr_o)
        else record_failure($sformatf("FAILED pslverr_o: got %h, expected 1", pslverr_o));
    a_unmapped_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (acc && slot > `SLOT_GPIO) |-> prdata_o == `ERR_RDATA)
        else record_failure($sformatf("FAILED prdata_o: got %h, expected %h",
            prdata_o, `ERR_RDATA));
    a_mapped_ok: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (acc && slot <= `SLOT_GPIO) |-> !pslverr_o)
        else record_failure($sformatf("FAILED pslverr_o: got %h, expected 0", pslverr_o));

    // ------------------------------------------------
    // GPIO and timer
    // ------------------------------------------------
    a_led_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wr_acc && slot == `SLOT_GPIO && idx == 3'd0) |=> leds_o == led_model)
        else record_failure($sformatf("FAILED leds_o: got %h, expected %h", leds_o, led_model));
    a_led_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_acc && slot == `SLOT_GPIO && idx == 3'd0) |-> prdata_o == pdata_t'(led_model))
        else record_failure($sformatf("FAILED prdata_o: got %h, expected %h",
            prdata_o, pdata_t'(led_model)));
    a_dip_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_acc && slot == `SLOT_GPIO && idx == 3'd1 && dip_stable >= 2'd2
            && dip_switches_i == dip_last) |-> prdata_o == pdata_t'(dip_switches_i))
        else record_failure($sformatf("FAILED prdata_o: got %h, expected %h",
            prdata_o, pdata_t'(dip_switches_i)));
    a_cnt0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_acc && slot == `SLOT_TIMER && idx == 3'd0) |-> prdata_o <= cmp_model[0])
        else record_failure($sformatf("FAILED prdata_o: count %h above compare %h",
            prdata_o, cmp_model[0]));
    a_cnt1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_acc && slot == `SLOT_TIMER && idx == 3'd4) |-> prdata_o <= cmp_model[1])
        else record_failure($sformatf("FAILED prdata_o: count %h above compare %h",
            prdata_o, cmp_model[1]));

    // ------------------------------------------------
    // Interrupt gateway
    // ------------------------------------------------
    a_tgt0_off: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_model[0] == '0) |-> !irq_o[0])
        else record_failure($sformatf("FAILED irq_o: got %h with target 0 masked", irq_o));
    a_tgt1_off: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_model[1] == '0) |-> !irq_o[1])
        else record_failure($sformatf("FAILED irq_o: got %h with target 1 masked", irq_o));
    a_clear: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wr_acc && slot == `SLOT_IRQ && idx == 3'd0 && pwdata_i[0] && en_model[0] == 4'b0001)
        |=> (!irq_o[0] || $past(irq_sources_i[0])))
        else record_failure($sformatf("FAILED irq_o: got %h after pending clear", irq_o));
    a_ext0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ext_irq_i[0] && en_model[1][2]) |=> irq_o[1])
        else record_failure($sformatf("FAILED irq_o: got %h after ext_irq_i[0]", irq_o));
    a_ext1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ext_irq_i[1] && en_model[1][3]) |=> irq_o[1])
        else record_failure($sformatf("FAILED irq_o: got %h after ext_irq_i[1]", irq_o));

endmodule

bind periph_top periph_chk i_chk (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .psel_i         ( psel_i         ),
    .penable_i      ( penable_i      ),
    .pwrite_i       ( pwrite_i       ),
    .paddr_i        ( paddr_i        ),
    .pwdata_i       ( pwdata_i       ),
    .prdata_o       ( prdata_o       ),
    .pready_o       ( pready_o       ),
    .pslverr_o      ( pslverr_o      ),
    .ext_irq_i      ( ext_irq_i      ),
    .irq_o          ( irq_o          ),
    .dip_switches_i ( dip_switches_i ),
    .leds_o         ( leds_o         ),
    .irq_sources_i  ( irq_sources    )
);

/* test/periph_tb.sv */
// Peripheral subsystem testbench
`include "periph_params.svh"

module periph_tb import periph_pkg::*; ();

    localparam int BUS_TIMEOUT = 8;

    logic       clk;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    paddr_t     paddr;
    pdata_t     pwdata;
    pdata_t     prdata;
    logic       pready;
    logic       pslverr;
    logic [1:0] ext_irq;
    irq_tgt_t   irq;
    gpio_t      dip;
    gpio_t      leds;
    int         tb_errors;

    periph_top dut (
        .clk_i          ( clk     ),
        .arst_n_i       ( arst_n  ),
        .psel_i         ( psel    ),
        .penable_i      ( penable ),
        .pwrite_i       ( pwrite  ),
        .paddr_i        ( paddr   ),
        .pwdata_i       ( pwdata  ),
        .prdata_o       ( prdata  ),
        .pready_o       ( pready  ),
        .pslverr_o      ( pslverr ),
        .ext_irq_i      ( ext_irq ),
        .irq_o          ( irq     ),
        .dip_switches_i ( dip     ),
        .leds_o         ( leds    )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic paddr_t reg_addr(input slot_t slot, input reg_idx_t idx);
        paddr_t addr;
        addr = '0;
        addr[`SLOT_LSB +: `SLOT_W]   = slot;
        addr[`REG_LSB +: `REG_IDX_W] = idx;
        return addr;
    endfunction

    // ------------------------------------------------
    // Bus access and interrupt waits
    // ------------------------------------------------
    task automatic apb_transfer(input logic wr, input paddr_t addr, input pdata_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;  // Setup cycle
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < BUS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            tb_errors++;
            $display("Bus transfer to address %h got no ready", addr);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic wait_irq(input int tgt, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq[tgt] && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!irq[tgt]) begin
            tb_errors++;
            $display("Interrupt target %0d did not rise within %0d cycles", tgt, limit);
        end
    endtask

    initial begin
        int    cmp0;
        int    cmp1;
        slot_t bad_slot;
        void'($urandom(40390));
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        ext_irq   = '0;
        dip       = '0;
        tb_errors = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Absent peripherals
        for (int i = 0; i < 6; i++) begin
            bad_slot = slot_t'(3 + $urandom_range(12));
            apb_transfer(1'(i % 2), reg_addr(bad_slot, reg_idx_t'($urandom_range(7))), $urandom);
        end

        // LEDs and switches
        for (int i = 0; i < 4; i++) begin
            apb_transfer(1'b1, reg_addr(`SLOT_GPIO, 3'd0), $urandom);
            apb_transfer(1'b0, reg_addr(`SLOT_GPIO, 3'd0), '0);
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            dip <= gpio_t'($urandom);
            repeat (4) @(posedge clk);
            apb_transfer(1'b0, reg_addr(`SLOT_GPIO, 3'd1), '0);
        end

        // ------------------------------------------------
        // Timer 0 into target 0
        // ------------------------------------------------
        cmp0 = 2 + $urandom_range(7);
        apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd1), 32'h1);
        apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd2), 32'h0);
        apb_transfer(1'b1, reg_addr(`SLOT_TIMER, 3'd2), pdata_t'(cmp0));
        apb_transfer(1'b1, reg_addr(`SLOT_TIMER, 3'd1), 32'h1);
        wait_irq(0, cmp0 + 3);
        for (int i = 0; i < 4; i++) begin
            apb_transfer(1'b0, reg_addr(`SLOT_TIMER, 3'd0), '0);
            apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd0), 32'h1);
            wait_irq(0, cmp0 + 4);  // Next match
        end
        apb_transfer(1'b1, reg_addr(`SLOT_TIMER, 3'd1), 32'h0);

        // Timer 1 runs unrouted
        cmp1 = 2 + $urandom_range(13);
        apb_transfer(1'b1, reg_addr(`SLOT_TIMER, 3'd6), pdata_t'(cmp1));
        apb_transfer(1'b1, reg_addr(`SLOT_TIMER, 3'd5), 32'h1);
        for (int i = 0; i < 8; i++) begin
            apb_transfer(1'b0, reg_addr(`SLOT_TIMER, 3'd4), '0);
        end

        // ------------------------------------------------
        // External lines into target 1
        // ------------------------------------------------
        apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd1), 32'h0);
        apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd2), 32'hC);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            ext_irq <= 2'(1 << (i % 2));
            @(posedge clk);
            ext_irq <= 2'b00;
            wait_irq(1, 3);
            apb_transfer(1'b1, reg_addr(`SLOT_IRQ, 3'd0), 32'hF);
        end

        repeat (4) @(posedge clk);
        $display("Checker errors: %0d, testbench errors: %0d", dut.i_chk.err_cnt, tb_errors);
        if (dut.i_chk.err_cnt == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/periph_pkg.sv
hw/apb_ctrl.sv
hw/gpio_regs.sv
hw/irq_gateway.sv
timer/apb_timer_unit.sv
hw/periph_top.sv
test/periph_chk.sv
test/periph_tb.sv

/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
